//--- logic/iq_macros.svh
`ifndef IQ_MACROS_SVH
`define IQ_MACROS_SVH

// datapath width
`define IQ_XLEN 32

// physical register tag width
`define IQ_TAG_W 5

// default slots per cluster
`define IQ_DEPTH 4

// age counter saturation value
`define IQ_AGE_MAX 15

`endif

//--- logic/iq_pkg.sv
`default_nettype none

`include "iq_macros.svh"

package iq_pkg;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_slt,
        op_beq,
        op_bne,
        op_blt,
        op_jal
    } op_e;

    typedef logic [$clog2(`IQ_AGE_MAX + 1) - 1:0] age_t;

    // 1 + 5 + 32 bits
    typedef struct packed {
        logic                  ready;
        logic [`IQ_TAG_W-1:0]  tag;
        logic [`IQ_XLEN-1:0]   value;
    } src_t;

    typedef struct packed {
        op_e                   op;
        src_t                  src1;
        src_t                  src2;
        logic [`IQ_TAG_W-1:0]  dst;
        logic [`IQ_XLEN-1:0]   pc;
        logic [`IQ_XLEN-1:0]   imm;
    } disp_t;

    typedef struct packed {
        logic                  valid;
        logic [`IQ_TAG_W-1:0]  tag;
        logic [`IQ_XLEN-1:0]   value;
        logic                  taken;
        logic [`IQ_XLEN-1:0]   target;
        logic                  qid;
    } cdb_t;

    typedef struct packed {
        logic [`IQ_XLEN-1:0]   value;
        logic                  taken;
        logic [`IQ_XLEN-1:0]   target;
    } exec_res_t;

endpackage

`default_nettype wire

//--- logic/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
    input  iq_pkg::disp_t      inst_i,
    output iq_pkg::exec_res_t  res_o
);

    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] link;
    logic [31:0] br_target;

    assign a         = inst_i.src1.value;
    assign b         = inst_i.src2.value;
    assign link      = inst_i.pc + 32'd4;
    assign br_target = inst_i.pc + inst_i.imm;

    always_comb begin
        res_o = '0;
        unique case (inst_i.op)
            iq_pkg::op_add: res_o.value = a + b;
            iq_pkg::op_sub: res_o.value = a - b;
            iq_pkg::op_and: res_o.value = a & b;
            iq_pkg::op_or:  res_o.value = a | b;
            iq_pkg::op_xor: res_o.value = a ^ b;
            iq_pkg::op_sll: res_o.value = a << b[4:0];
            iq_pkg::op_srl: res_o.value = a >> b[4:0];
            iq_pkg::op_slt: res_o.value = {31'd0, $signed(a) < $signed(b)};
            ////////////////////
            // branches
            iq_pkg::op_beq,
            iq_pkg::op_bne,
            iq_pkg::op_blt,
            iq_pkg::op_jal: begin
                res_o.value  = link;
                res_o.target = br_target;
                case (inst_i.op)
                    iq_pkg::op_beq: res_o.taken = (a == b);
                    iq_pkg::op_bne: res_o.taken = (a != b);
                    iq_pkg::op_blt: res_o.taken = $signed(a) < $signed(b);
                    default:        res_o.taken = 1'b1;
                endcase
            end
            default: res_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/cdb_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module cdb_arbiter (
    input  wire logic        clk,
    input  wire logic        rst_n_i,
    input  wire logic        flush_i,
    input  wire logic [1:0]  req_i,
    input  iq_pkg::cdb_t     res0_i,
    input  iq_pkg::cdb_t     res1_i,
    output logic [1:0]       grant_o,
    output iq_pkg::cdb_t     cdb_o
);

    // cluster that wins the next tie
    logic prio_q;

    always_comb begin
        grant_o = 2'b00;
        if (!flush_i) begin
            if (&req_i) begin
                grant_o = prio_q ? 2'b10 : 2'b01;
            end else begin
                grant_o = req_i;
            end
        end
    end

    always_comb begin
        cdb_o = '0;
        if (grant_o[1]) begin
            cdb_o = res1_i;
        end else if (grant_o[0]) begin
            cdb_o = res0_i;
        end
        cdb_o.valid = |grant_o;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_q <= 1'b0;
        end else if (flush_i) begin
            prio_q <= 1'b0;
        end else if (grant_o[0]) begin
            prio_q <= 1'b1;
        end else if (grant_o[1]) begin
            prio_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/iq_entry.sv
`timescale 1ns/1ns
`default_nettype none

`include "iq_macros.svh"

module iq_entry (
    input  wire logic          clk,
    input  wire logic          rst_n_i,
    input  wire logic          flush_i,
    input  wire logic          alloc_i,
    input  iq_pkg::disp_t      disp_i,
    input  iq_pkg::cdb_t       cdb_i,
    input  wire logic          issue_i,
    output logic               busy_o,
    output logic               ready_o,
    output iq_pkg::age_t       age_o,
    output iq_pkg::disp_t      inst_o
);

    logic          busy_q;
    iq_pkg::age_t  age_q;
    iq_pkg::disp_t inst_q;
    iq_pkg::disp_t inst_d;

    // capture a broadcast value for a waiting source
    function automatic iq_pkg::src_t snoop(iq_pkg::src_t s, iq_pkg::cdb_t c);
        iq_pkg::src_t r;
        r = s;
        if (!s.ready && c.valid && (c.tag == s.tag)) begin
            r.ready = 1'b1;
            r.value = c.value;
        end
        return r;
    endfunction

    // a fresh dispatch snoops the same bus cycle too
    always_comb begin
        inst_d = alloc_i ? disp_i : inst_q;
        inst_d.src1 = snoop(inst_d.src1, cdb_i);
        inst_d.src2 = snoop(inst_d.src2, cdb_i);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            age_q  <= '0;
        end else if (flush_i) begin
            busy_q <= 1'b0;
            age_q  <= '0;
        end else if (alloc_i) begin
            busy_q <= 1'b1;
            age_q  <= '0;
        end else begin
            if (issue_i) begin
                busy_q <= 1'b0;
            end
            if (busy_q && (age_q != iq_pkg::age_t'(`IQ_AGE_MAX))) begin
                age_q <= age_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        inst_q <= inst_d;
    end

    assign busy_o  = busy_q;
    assign ready_o = busy_q & inst_q.src1.ready & inst_q.src2.ready;
    assign age_o   = age_q;
    assign inst_o  = inst_q;

endmodule

`default_nettype wire

//--- logic/alu_iq.sv
`timescale 1ns/1ns
`default_nettype none

`include "iq_macros.svh"

module alu_iq #(
    parameter int depth = `IQ_DEPTH
) (
    input  wire logic          clk,
    input  wire logic          rst_n_i,
    input  wire logic          flush_i,
    input  wire logic          qid_i,
    input  iq_pkg::disp_t      disp_i,
    input  wire logic          disp_valid_i,
    output logic               disp_ready_o,
    input  iq_pkg::cdb_t       cdb_i,
    output logic               req_o,
    output iq_pkg::cdb_t       res_o,
    input  wire logic          grant_i
);

    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;

    logic [depth-1:0]   busy;
    logic [depth-1:0]   rdy;
    logic [depth-1:0]   alloc_vec;
    logic [depth-1:0]   issue_vec;
    iq_pkg::age_t       age [depth];
    iq_pkg::disp_t      inst [depth];

    logic               accept;
    logic               any_rdy;
    logic               issue_en;
    logic [idx_w-1:0]   sel_idx;
    iq_pkg::age_t       best_age;
    iq_pkg::disp_t      sel_inst;
    iq_pkg::exec_res_t  exec_res;

    logic               ready_q;
    logic               res_valid_q;
    logic [`IQ_TAG_W-1:0] res_tag_q;
    iq_pkg::exec_res_t  res_q;

    ////////////////////
    // allocation
    assign accept = disp_valid_i & ready_q & ~flush_i;

    // lowest free slot wins
    always_comb begin
        alloc_vec = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                alloc_vec    = '0;
                alloc_vec[i] = accept;
            end
        end
    end

    // free slot left after this edge
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ready_q <= 1'b1;
        end else if (flush_i) begin
            ready_q <= 1'b1;
        end else begin
            ready_q <= |((~busy & ~alloc_vec) | issue_vec);
        end
    end

    for (genvar i = 0; i < depth; i++) begin : g_slot
        assign issue_vec[i] = issue_en & (sel_idx == idx_w'(i));

        iq_entry u_entry (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .flush_i (flush_i),
            .alloc_i (alloc_vec[i]),
            .disp_i  (disp_i),
            .cdb_i   (cdb_i),
            .issue_i (issue_vec[i]),
            .busy_o  (busy[i]),
            .ready_o (rdy[i]),
            .age_o   (age[i]),
            .inst_o  (inst[i])
        );
    end

    ////////////////////
    // oldest ready slot wins and ties go to the lowest index
    always_comb begin
        sel_idx  = '0;
        best_age = '0;
        any_rdy  = 1'b0;
        for (int i = 0; i < depth; i++) begin
            if (rdy[i] && (!any_rdy || (age[i] > best_age))) begin
                sel_idx  = idx_w'(i);
                best_age = age[i];
                any_rdy  = 1'b1;
            end
        end
    end

    assign issue_en = any_rdy & (~res_valid_q | grant_i) & ~flush_i;
    assign sel_inst = inst[sel_idx];

    exec_unit u_exec (
        .inst_i (sel_inst),
        .res_o  (exec_res)
    );

    ////////////////////
    // result register held until granted
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (flush_i) begin
            res_valid_q <= 1'b0;
        end else if (issue_en) begin
            res_valid_q <= 1'b1;
        end else if (grant_i) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_en) begin
            res_q     <= exec_res;
            res_tag_q <= sel_inst.dst;
        end
    end

    assign disp_ready_o = ready_q;
    assign req_o        = res_valid_q;

    always_comb begin
        res_o        = '0;
        res_o.valid  = res_valid_q;
        res_o.tag    = res_tag_q;
        res_o.value  = res_q.value;
        res_o.taken  = res_q.taken;
        res_o.target = res_q.target;
        res_o.qid    = qid_i;
    end

endmodule

`default_nettype wire

//--- logic/issue_top.sv
`timescale 1ns/1ns
`default_nettype none

module issue_top (
    input  wire logic      clk,
    input  wire logic      rst_n_i,
    input  wire logic      flush_i,
    input  iq_pkg::disp_t  disp0_i,
    input  wire logic      disp0_valid_i,
    output logic           disp0_ready_o,
    input  iq_pkg::disp_t  disp1_i,
    input  wire logic      disp1_valid_i,
    output logic           disp1_ready_o,
    output iq_pkg::cdb_t   cdb_o
);

    logic [1:0]    req;
    logic [1:0]    grant;
    iq_pkg::cdb_t  res0;
    iq_pkg::cdb_t  res1;

    // both clusters snoop the same broadcast
    alu_iq u_iq0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .qid_i        (1'b0),
        .disp_i       (disp0_i),
        .disp_valid_i (disp0_valid_i),
        .disp_ready_o (disp0_ready_o),
        .cdb_i        (cdb_o),
        .req_o        (req[0]),
        .res_o        (res0),
        .grant_i      (grant[0])
    );

    alu_iq u_iq1 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .qid_i        (1'b1),
        .disp_i       (disp1_i),
        .disp_valid_i (disp1_valid_i),
        .disp_ready_o (disp1_ready_o),
        .cdb_i        (cdb_o),
        .req_o        (req[1]),
        .res_o        (res1),
        .grant_i      (grant[1])
    );

    cdb_arbiter u_arb (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .req_i   (req),
        .res0_i  (res0),
        .res1_i  (res1),
        .grant_o (grant),
        .cdb_o   (cdb_o)
    );

endmodule

`default_nettype wire

//--- tb/issue_assert.sv
`timescale 1ns/1ns
`default_nettype none

module issue_assert (
    input  wire logic          clk,
    input  wire logic          rst_n_i,
    input  wire logic          flush_i,
    input  wire logic [1:0]    req_i,
    input  wire logic [1:0]    grant_i,
    input  wire iq_pkg::cdb_t  cdb_i
);

    // one owner of the bus at a time
    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(grant_i))
        else $error("grant is not one-hot or zero");

    a_lone_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!flush_i && $onehot(req_i)) |-> (grant_i == req_i))
        else $error("a lone request was not granted");

    // result registers are emptied by flush
    a_flush_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> !cdb_i.valid)
        else $error("bus valid in the cycle after flush");

endmodule

bind cdb_arbiter issue_assert u_assert (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .req_i   (req_i),
    .grant_i (grant_o),
    .cdb_i   (cdb_o)
);

`default_nettype wire

//--- tb/issue_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "iq_macros.svh"

module issue_tb;

    localparam int num_instr    = 400;
    localparam int alu_phase    = 100;
    localparam int flush_at     = 300;
    localparam int reset_cycles = 16;
    localparam int max_inflight = `IQ_DEPTH + 1;

    logic          clk;
    logic          rst_n;
    logic          flush;
    iq_pkg::disp_t disp [2];
    logic [1:0]    disp_valid;
    logic [1:0]    disp_ready;
    iq_pkg::cdb_t  cdb;

    integer        seed = 98360;
    bit            inflight [32];
    iq_pkg::disp_t rec [32];
    logic          rec_qid [32];
    logic [31:0]   model_val [32];
    bit            held [2];
    int            cnt [2];
    bit            prio;
    bit            check_ready;
    bit            flushed;
    int            generated;
    int            value_errs;
    int            proto_errs;
    int            cover_errs;
    int            full_seen;
    int            alt_seen;
    int            same_seen;

    issue_top dut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .flush_i       (flush),
        .disp0_i       (disp[0]),
        .disp0_valid_i (disp_valid[0]),
        .disp0_ready_o (disp_ready[0]),
        .disp1_i       (disp[1]),
        .disp1_valid_i (disp_valid[1]),
        .disp1_ready_o (disp_ready[1]),
        .cdb_o         (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // small values now and then so compares hit equality
    function automatic logic [31:0] rand_value();
        logic [31:0] r;
        r = $random(seed);
        if (rand_below(3) == 0) begin
            r = 32'(rand_below(4));
        end
        return r;
    endfunction

    ////////////////////
    // reference model
    function automatic iq_pkg::cdb_t predict(iq_pkg::disp_t d, logic qid);
        iq_pkg::cdb_t e;
        logic [31:0]  a;
        logic [31:0]  b;
        a = d.src1.value;
        b = d.src2.value;
        e = '0;
        e.valid = 1'b1;
        e.tag   = d.dst;
        e.qid   = qid;
        case (d.op)
            iq_pkg::op_add: e.value = a + b;
            iq_pkg::op_sub: e.value = a - b;
            iq_pkg::op_and: e.value = a & b;
            iq_pkg::op_or:  e.value = a | b;
            iq_pkg::op_xor: e.value = a ^ b;
            iq_pkg::op_sll: e.value = a << b[4:0];
            iq_pkg::op_srl: e.value = a >> b[4:0];
            iq_pkg::op_slt: e.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: begin
                e.value  = d.pc + 32'd4;
                e.target = d.pc + d.imm;
                case (d.op)
                    iq_pkg::op_beq: e.taken = (a == b);
                    iq_pkg::op_bne: e.taken = (a != b);
                    iq_pkg::op_blt: e.taken = ($signed(a) < $signed(b));
                    default:        e.taken = 1'b1;
                endcase
            end
        endcase
        return e;
    endfunction

    // a source whose producer already broadcast takes the model value
    function automatic iq_pkg::src_t resolve(iq_pkg::src_t s);
        iq_pkg::src_t r;
        r = s;
        if (!s.ready && !inflight[s.tag]) begin
            r.ready = 1'b1;
            r.value = model_val[s.tag];
        end
        return r;
    endfunction

    function automatic iq_pkg::src_t pick_source(int dep_pct);
        iq_pkg::src_t s;
        logic [4:0]   t;
        s.ready = 1'b1;
        s.tag   = '0;
        s.value = rand_value();
        if (rand_below(100) < dep_pct) begin
            for (int k = 0; k < 8; k++) begin
                t = 5'(rand_below(32));
                if (s.ready && inflight[t]) begin
                    s.ready = 1'b0;
                    s.tag   = t;
                    s.value = '0;
                end
            end
        end
        return s;
    endfunction

    task automatic make_instr(input int q, input bit alu_only, input int dep_pct);
        iq_pkg::disp_t d;
        logic [4:0]    t;
        d = '0;
        // tag must be free and not held by the other driver
        t = 5'(rand_below(32));
        while (inflight[t] || (held[1 - q] && disp[1 - q].dst == t)) begin
            t = 5'(rand_below(32));
        end
        d.op      = iq_pkg::op_e'(4'(rand_below(alu_only ? 8 : 12)));
        d.src1    = pick_source(dep_pct);
        d.src2    = pick_source(dep_pct);
        d.dst     = t;
        d.pc      = $random(seed);
        d.pc[1:0] = 2'b00;
        d.imm     = rand_value();
        disp[q]   = d;
        held[q]   = 1'b1;
        generated++;
    endtask

    task automatic drive_cycle(input bit alu_only, input int dep_pct);
        for (int q = 0; q < 2; q++) begin
            if (held[q]) begin
                disp[q].src1 = resolve(disp[q].src1);
                disp[q].src2 = resolve(disp[q].src2);
            end else if (generated < num_instr && rand_below(4) != 0) begin
                make_instr(q, alu_only, dep_pct);
            end
            disp_valid[q] = held[q];
        end
    endtask

    task automatic observe_cycle();
        iq_pkg::cdb_t  exp;
        iq_pkg::disp_t d;
        logic [4:0]    t;
        for (int q = 0; q < 2; q++) begin
            if (cnt[q] == max_inflight) begin
                full_seen++;
            end
            assert (!(cnt[q] >= max_inflight && disp_ready[q])) else begin
                proto_errs++;
                $display("** Error @%0t: cluster %0d full but ready high", $time, q);
            end
            assert (!(check_ready && !disp_ready[q])) else begin
                proto_errs++;
                $display("** Error @%0t: cluster %0d ready low after flush", $time, q);
            end
        end
        check_ready = 1'b0;
        if (flush) begin
            assert (!cdb.valid) else begin
                proto_errs++;
                $display("** Error @%0t: bus valid during flush", $time);
            end
            for (int i = 0; i < 32; i++) begin
                inflight[i] = 1'b0;
            end
            cnt[0]      = 0;
            cnt[1]      = 0;
            held[0]     = 1'b0;
            held[1]     = 1'b0;
            prio        = 1'b0;
            check_ready = 1'b1;
            return;
        end
        if (cdb.valid) begin
            t = cdb.tag;
            if (dut.req == 2'b11) begin
                alt_seen++;
                assert (cdb.qid == prio) else begin
                    proto_errs++;
                    $display("** Error @%0t: grant went to cluster %0d twice", $time, cdb.qid);
                end
            end
            prio = ~cdb.qid;
            assert (inflight[t]) else begin
                proto_errs++;
                $display("** Error @%0t: tag %0d on the bus is not in flight", $time, t);
            end
            if (inflight[t]) begin
                exp = predict(rec[t], rec_qid[t]);
                assert (rec[t].src1.ready && rec[t].src2.ready) else begin
                    proto_errs++;
                    $display("** Error @%0t: tag %0d issued before its sources", $time, t);
                end
                assert (cdb == exp) else begin
                    value_errs++;
                    $display("** Error @%0t: tag %0d got %h/%b/%h/q%b, expected %h/%b/%h/q%b",
                             $time, t, cdb.value, cdb.taken, cdb.target, cdb.qid,
                             exp.value, exp.taken, exp.target, exp.qid);
                end
                model_val[t] = exp.value;
                inflight[t]  = 1'b0;
                cnt[rec_qid[t]]--;
                for (int i = 0; i < 32; i++) begin
                    if (inflight[i]) begin
                        rec[i].src1 = resolve(rec[i].src1);
                        rec[i].src2 = resolve(rec[i].src2);
                    end
                end
            end
        end
        for (int q = 0; q < 2; q++) begin
            if (disp_valid[q] && disp_ready[q]) begin
                d = disp[q];
                // producer broadcast in this very cycle
                if ((!d.src1.ready && !inflight[d.src1.tag]) ||
                    (!d.src2.ready && !inflight[d.src2.tag])) begin
                    same_seen++;
                end
                d.src1          = resolve(d.src1);
                d.src2          = resolve(d.src2);
                rec[d.dst]      = d;
                rec_qid[d.dst]  = 1'(q);
                inflight[d.dst] = 1'b1;
                cnt[q]++;
                held[q] = 1'b0;
            end
        end
    endtask

    ////////////////////
    // main sequence
    initial begin
        rst_n       = 1'b0;
        flush       = 1'b0;
        disp[0]     = '0;
        disp[1]     = '0;
        disp_valid  = 2'b00;
        check_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (generated < num_instr || held[0] || held[1]) begin
            @(posedge clk);
            #1;
            flush = (generated >= flush_at) && !flushed;
            if (flush) begin
                flushed = 1'b1;
            end
            drive_cycle(generated < alu_phase, (generated < alu_phase) ? 0 : 50);
            @(negedge clk);
            observe_cycle();
        end
        // drain, then watch for stray broadcasts
        @(posedge clk);
        #1;
        flush      = 1'b0;
        disp_valid = 2'b00;
        while (cnt[0] + cnt[1] > 0) begin
            @(negedge clk);
            observe_cycle();
        end
        repeat (10) begin
            @(negedge clk);
            observe_cycle();
        end
        assert (full_seen > 0) else begin
            cover_errs++;
            $display("no cluster was ever filled");
        end
        assert (alt_seen > 0) else begin
            cover_errs++;
            $display("the two clusters never requested the bus together");
        end
        assert (same_seen > 0) else begin
            cover_errs++;
            $display("no dispatch ever met its producer's broadcast");
        end
        $display("errors: value %0d, protocol %0d, coverage %0d",
                 value_errs, proto_errs, cover_errs);
        if (value_errs + proto_errs + cover_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((num_instr * 40 + reset_cycles) * 10);
        $display("timeout: results still outstanding after %0d cycles",
                 num_instr * 40 + reset_cycles);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+logic
logic/iq_pkg.sv
logic/exec_unit.sv
logic/cdb_arbiter.sv
logic/iq_entry.sv
logic/alu_iq.sv
logic/issue_top.sv
tb/issue_assert.sv
tb/issue_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module issue_tb \
    -f verilog.f -o issue_sim > build.log 2>&1 \
    && ./obj_dir/issue_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && exit 1
exit 0
